// File: all.f
+incdir+hw
hw/mem_pkg.sv
hw/mem_port_if.sv
hw/dual_port_ram.sv
hw/port_arbiter.sv
hw/load_store_unit.sv
hw/block_copier.sv
hw/data_mem_subsys.sv
tests/tb_data_mem_subsys.sv

// File: tests/tb_data_mem_subsys.sv
`timescale 1ns/10ps
`include "mem_params.svh"

// Directed testbench for the data memory subsystem
// Inputs change on the rising edge and outputs are sampled on the falling edge
module tb_data_mem_subsys;

    // All directed tests together take about 1500 cycles
    localparam int MAX_CYCLES = 20000;

    logic                     iw_clk;
    logic                     rst;
    logic                     cpu_req;
    logic                     cpu_we;
    logic                     cpu_is48;
    logic                     cpu_signed;
    logic [`MEM_ADDR_W-1:0]   cpu_addr;
    logic [2*`MEM_WORD_W-1:0] cpu_wdata;
    logic                     cpu_ready;
    logic                     cpu_rvalid;
    logic [2*`MEM_WORD_W-1:0] cpu_rdata;
    logic                     cpy_start;
    logic [`MEM_ADDR_W-1:0]   cpy_src;
    logic [`MEM_ADDR_W-1:0]   cpy_dst;
    logic [`MEM_ADDR_W-1:0]   cpy_count;
    logic                     cpy_busy;
    logic                     cpy_done;

    // Reference copy of the RAM with one entry per 24-bit word
    logic [`MEM_WORD_W-1:0] model [`MEM_DEPTH];

    int errors = 0;
    int cycles = 0;
    int seed = 32'h9609;

    data_mem_subsys data_mem_subsys_i (.*);

    initial begin
        iw_clk = 1'b0;
        forever #50 iw_clk = ~iw_clk;
    end

    // A stalled handshake ends the run at the cycle limit
    always @(posedge iw_clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Errors: %0d", errors);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [`MEM_WORD_W-1:0] rand24();
        logic [31:0] r;
        r = $random(seed);
        return r[`MEM_WORD_W-1:0];
    endfunction

    // Expected load value taken from the model
    // A 48-bit load is {addr+1, addr} and a 24-bit load is zero or sign filled
    function automatic logic [47:0] model_load(input logic [11:0] addr, input logic is48,
                                               input logic sgn);
        logic [11:0] a1;
        logic [23:0] lo;
        logic [23:0] hi;
        a1 = addr + 1'b1;
        lo = model[addr];
        if (is48)
            hi = model[a1];
        else if (sgn)
            hi = {24{lo[23]}};
        else
            hi = '0;
        return {hi, lo};
    endfunction

    task automatic wait_ready();
        @(negedge iw_clk);
        while (!cpu_ready) @(negedge iw_clk);
    endtask

    task automatic cpu_store(input logic [11:0] addr, input logic is48, input logic [47:0] data);
        logic [11:0] a1;
        a1 = addr + 1'b1;
        wait_ready();
        @(posedge iw_clk);
        cpu_req    <= 1'b1;
        cpu_we     <= 1'b1;
        cpu_is48   <= is48;
        cpu_signed <= 1'b0;
        cpu_addr   <= addr;
        cpu_wdata  <= data;
        @(posedge iw_clk);
        cpu_req <= 1'b0;
        // The store is done once the buffer is free again
        wait_ready();
        model[addr] = data[23:0];
        if (is48)
            model[a1] = data[47:24];
    endtask

    task automatic load_raw(input logic [11:0] addr, input logic is48, input logic sgn,
                            output logic [47:0] data);
        wait_ready();
        @(posedge iw_clk);
        cpu_req    <= 1'b1;
        cpu_we     <= 1'b0;
        cpu_is48   <= is48;
        cpu_signed <= sgn;
        cpu_addr   <= addr;
        @(posedge iw_clk);
        cpu_req <= 1'b0;
        @(negedge iw_clk);
        while (!cpu_rvalid) @(negedge iw_clk);
        data = cpu_rdata;
    endtask

    task automatic cpu_load(input string name, input logic [11:0] addr, input logic is48,
                            input logic sgn);
        logic [47:0] act;
        logic [47:0] exp;
        load_raw(addr, is48, sgn, act);
        exp = model_load(addr, is48, sgn);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s addr %h: expected %h, actual %h", name, addr, exp, act);
        end
    endtask

    task automatic fill_random(input logic [11:0] base, input int count);
        int i;
        for (i = 0; i < count; i += 2) begin
            cpu_store(base + 12'(i), 1'b1, {rand24(), rand24()});
        end
    endtask

    task automatic run_copy(input logic [11:0] src, input logic [11:0] dst, input int count);
        int i;
        @(negedge iw_clk);
        while (cpy_busy) @(negedge iw_clk);
        @(posedge iw_clk);
        cpy_start <= 1'b1;
        cpy_src   <= src;
        cpy_dst   <= dst;
        cpy_count <= 12'(count);
        @(posedge iw_clk);
        cpy_start <= 1'b0;
        @(negedge iw_clk);
        while (!cpy_done) @(negedge iw_clk);
        // Regions never overlap, so a forward word loop matches the copy
        for (i = 0; i < count; i++) begin
            model[dst + 12'(i)] = model[src + 12'(i)];
        end
    endtask

    // Destination words plus the two words right past the end
    task automatic check_copy(input string name, input logic [11:0] dst, input int count);
        int i;
        for (i = 0; i < count + 2; i++) begin
            cpu_load(name, dst + 12'(i), 1'b0, 1'b0);
        end
    endtask

    task automatic reset_values();
        @(negedge iw_clk);
        if (cpu_ready !== 1'b1) begin
            errors++;
            $display("[FAIL] reset_values cpu_ready: expected 1, actual %b", cpu_ready);
        end
        if (cpy_busy !== 1'b0) begin
            errors++;
            $display("[FAIL] reset_values cpy_busy: expected 0, actual %b", cpy_busy);
        end
        if (cpy_done !== 1'b0) begin
            errors++;
            $display("[FAIL] reset_values cpy_done: expected 0, actual %b", cpy_done);
        end
        if (cpu_rvalid !== 1'b0) begin
            errors++;
            $display("[FAIL] reset_values cpu_rvalid: expected 0, actual %b", cpu_rvalid);
        end
    endtask

    task automatic store_and_load();
        logic [11:0] addr;
        int i;
        for (i = 0; i < 8; i++) begin
            cpu_store(12'h100 + 12'(4 * i), i[0], {rand24(), rand24()});
        end
        for (i = 0; i < 8; i++) begin
            addr = 12'h100 + 12'(4 * i);
            cpu_load("store_load", addr, 1'b1, 1'b0);
            cpu_load("store_load", addr, 1'b0, 1'b0);
            cpu_load("store_load", addr + 1'b1, 1'b0, 1'b0);
        end
        // A pair at the top word wraps round to word zero
        cpu_store(12'hfff, 1'b1, {rand24(), rand24()});
        cpu_load("store_load_wrap", 12'hfff, 1'b1, 1'b0);
        cpu_load("store_load_wrap", 12'h000, 1'b0, 1'b0);
    endtask

    task automatic signed_loads();
        cpu_store(12'h180, 1'b0, {24'h0, 24'h800001});
        cpu_store(12'h181, 1'b0, {24'h0, 24'h7ffffe});
        cpu_store(12'h182, 1'b0, {24'h0, rand24() | 24'h800000});
        cpu_store(12'h183, 1'b0, {24'h0, rand24() & 24'h7fffff});
        for (int i = 0; i < 4; i++) begin
            cpu_load("signed_load", 12'h180 + 12'(i), 1'b0, 1'b1);
            cpu_load("signed_load", 12'h180 + 12'(i), 1'b0, 1'b0);
        end
    endtask

    task automatic copy_counts();
        fill_random(12'h200, 24);
        // Non-zero neighbours make a stray write past the end visible
        fill_random(12'h300, 72);
        run_copy(12'h200, 12'h300, 10);
        check_copy("copy_even", 12'h300, 10);
        run_copy(12'h210, 12'h320, 7);
        check_copy("copy_odd", 12'h320, 7);
        run_copy(12'h220, 12'h340, 0);
        check_copy("copy_zero", 12'h340, 0);
    endtask

    task automatic copy_with_traffic();
        fill_random(12'h400, 60);
        fork
            run_copy(12'h400, 12'h600, 60);
            begin
                for (int k = 0; k < 12; k++) begin
                    cpu_store(12'h800 + 12'(k), k[0], {rand24(), rand24()});
                    cpu_load("copy_traffic", 12'h800 + 12'(k), k[0], 1'b0);
                end
            end
        join
        check_copy("copy_traffic", 12'h600, 60);
    endtask

    task automatic copy_forwarding();
        logic [23:0] old_val [60];
        logic [23:0] new_val [60];
        logic [47:0] act;
        int off;
        fill_random(12'h700, 60);
        // Snapshot both candidates before the model moves on at the end of the copy
        for (int i = 0; i < 60; i++) begin
            old_val[i] = model[12'h700 + 12'(i)];
            new_val[i] = model[12'h400 + 12'(i)];
        end
        fork
            run_copy(12'h400, 12'h700, 60);
            begin
                for (int k = 0; k < 20; k++) begin
                    off = (k * 7) % 60;
                    load_raw(12'h700 + 12'(off), 1'b0, 1'b0, act);
                    if ((act[23:0] !== old_val[off] && act[23:0] !== new_val[off]) ||
                        act[47:24] !== 24'h0) begin
                        errors++;
                        $display("[FAIL] copy_forwarding offset %0d: expected %h or %h, actual %h",
                                 off, old_val[off], new_val[off], act);
                    end
                end
            end
        join
        check_copy("copy_forwarding", 12'h700, 60);
    endtask

    initial begin
        for (int i = 0; i < `MEM_DEPTH; i++) begin
            model[i] = '0;
        end
        rst        = 1'b1;
        cpu_req    = 1'b0;
        cpu_we     = 1'b0;
        cpu_is48   = 1'b0;
        cpu_signed = 1'b0;
        cpu_addr   = '0;
        cpu_wdata  = '0;
        cpy_start  = 1'b0;
        cpy_src    = '0;
        cpy_dst    = '0;
        cpy_count  = '0;
        repeat (8) @(posedge iw_clk);
        rst <= 1'b0;
        reset_values();
        store_and_load();
        signed_loads();
        copy_counts();
        copy_with_traffic();
        copy_forwarding();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: hw/data_mem_subsys.sv
`timescale 1ns/10ps
`include "mem_params.svh"

// Data memory subsystem of the core
// The load/store unit and the copier share RAM port 0 through the arbiter
// and the copier writes on RAM port 1
module data_mem_subsys (
    input  logic                     iw_clk,
    input  logic                     rst,
    input  logic                     cpu_req,
    input  logic                     cpu_we,
    input  logic                     cpu_is48,
    input  logic                     cpu_signed,
    input  logic [`MEM_ADDR_W-1:0]   cpu_addr,
    input  logic [2*`MEM_WORD_W-1:0] cpu_wdata,
    output logic                     cpu_ready,
    output logic                     cpu_rvalid,
    output logic [2*`MEM_WORD_W-1:0] cpu_rdata,
    input  logic                     cpy_start,
    input  logic [`MEM_ADDR_W-1:0]   cpy_src,
    input  logic [`MEM_ADDR_W-1:0]   cpy_dst,
    input  logic [`MEM_ADDR_W-1:0]   cpy_count,
    output logic                     cpy_busy,
    output logic                     cpy_done
);

    // Peer ports into the arbiter
    mem_port_if lsu_port ();
    mem_port_if cpy_rd_port ();

    // RAM ports, port 1 carries copier writes only
    mem_port_if ram_p0 ();
    mem_port_if ram_p1 ();

    load_store_unit lsu_i (
        .iw_clk     (iw_clk),
        .rst        (rst),
        .cpu_req    (cpu_req),
        .cpu_we     (cpu_we),
        .cpu_is48   (cpu_is48),
        .cpu_signed (cpu_signed),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .cpu_ready  (cpu_ready),
        .cpu_rvalid (cpu_rvalid),
        .cpu_rdata  (cpu_rdata),
        .port       (lsu_port.requester)
    );

    block_copier copier_i (
        .iw_clk    (iw_clk),
        .rst       (rst),
        .cpy_start (cpy_start),
        .cpy_src   (cpy_src),
        .cpy_dst   (cpy_dst),
        .cpy_count (cpy_count),
        .cpy_busy  (cpy_busy),
        .cpy_done  (cpy_done),
        .rd        (cpy_rd_port.requester),
        .wr        (ram_p1.requester)
    );

    port_arbiter arb_i (
        .iw_clk (iw_clk),
        .rst    (rst),
        .lsu    (lsu_port.arbiter),
        .cpy    (cpy_rd_port.arbiter),
        .ram    (ram_p0.requester)
    );

    dual_port_ram ram_i (
        .iw_clk (iw_clk),
        .p0     (ram_p0.memory),
        .p1     (ram_p1.memory)
    );

endmodule

// File: hw/block_copier.sv
`timescale 1ns/10ps
`include "mem_params.svh"

// Block copier that moves cpy_count words from cpy_src to cpy_dst
// Reads go through the arbiter on port 0, writes go straight to port 1
module block_copier import mem_pkg::*; (
    input  logic                   iw_clk,
    input  logic                   rst,
    input  logic                   cpy_start,
    input  logic [`MEM_ADDR_W-1:0] cpy_src,
    input  logic [`MEM_ADDR_W-1:0] cpy_dst,
    input  logic [`MEM_ADDR_W-1:0] cpy_count,
    output logic                   cpy_busy,
    output logic                   cpy_done,
    mem_port_if.requester          rd,
    mem_port_if.requester          wr
);

    // Read side position and words still to be read
    logic [`MEM_ADDR_W-1:0] rd_addr;
    logic [`MEM_ADDR_W-1:0] rd_left;
    logic [`MEM_ADDR_W-1:0] rd_step;

    // Write side position and words still to be written
    logic [`MEM_ADDR_W-1:0] wr_addr;
    logic [`MEM_ADDR_W-1:0] wr_left;
    logic [`MEM_ADDR_W-1:0] wr_step;

    // Width of the read granted last cycle, that is the one now returning
    logic ret48;

    mem_word_u ret_word;

    // Pairs are read while two or more words remain, a final odd word alone
    assign rd.req   = cpy_busy && (rd_left != '0);
    assign rd.we    = 1'b0;
    assign rd.addr  = rd_addr;
    assign rd.is48  = (rd_left > `MEM_ADDR_W'(1));
    assign rd.wdata = '0;
    assign rd_step  = rd.is48 ? `MEM_ADDR_W'(2) : `MEM_ADDR_W'(1);

    // Each returning read is written in the same cycle at the same width
    assign ret_word = rd.rdata;
    assign wr.req   = rd.rvalid;
    assign wr.we    = 1'b1;
    assign wr.addr  = wr_addr;
    assign wr.is48  = ret48;
    assign wr.wdata = ret_word;
    assign wr_step  = ret48 ? `MEM_ADDR_W'(2) : `MEM_ADDR_W'(1);

    always_ff @(posedge iw_clk) begin
        if (rst) begin
            cpy_busy <= 1'b0;
            cpy_done <= 1'b0;
        end else begin
            cpy_done <= 1'b0;
            if (!cpy_busy && cpy_start) begin
                cpy_busy <= 1'b1;
                // An empty copy ends right away
                if (cpy_count == '0)
                    cpy_done <= 1'b1;
            end else if (cpy_done) begin
                cpy_busy <= 1'b0;
            end else if (rd.rvalid && wr_left == wr_step) begin
                // The last write goes out this cycle
                cpy_done <= 1'b1;
            end
        end
    end

    // Read and write counters move on their own, so reads can stack up
    // while earlier data is still on its way back
    always_ff @(posedge iw_clk) begin
        if (!cpy_busy && cpy_start) begin
            rd_addr <= cpy_src;
            rd_left <= cpy_count;
            wr_addr <= cpy_dst;
            wr_left <= cpy_count;
        end else begin
            if (rd.gnt) begin
                rd_addr <= rd_addr + rd_step;
                rd_left <= rd_left - rd_step;
            end
            if (rd.rvalid) begin
                wr_addr <= wr_addr + wr_step;
                wr_left <= wr_left - wr_step;
            end
        end
    end

    // Read data always returns exactly one cycle after the grant
    always_ff @(posedge iw_clk) begin
        ret48 <= rd.is48;
    end

endmodule

// File: hw/load_store_unit.sv
`timescale 1ns/10ps
`include "mem_params.svh"

// Load/store unit for the core
// It holds one request until the arbiter grants it and shapes the load data
module load_store_unit import mem_pkg::*; (
    input  logic                     iw_clk,
    input  logic                     rst,
    input  logic                     cpu_req,
    input  logic                     cpu_we,
    input  logic                     cpu_is48,
    input  logic                     cpu_signed,
    input  logic [`MEM_ADDR_W-1:0]   cpu_addr,
    input  logic [2*`MEM_WORD_W-1:0] cpu_wdata,
    output logic                     cpu_ready,
    output logic                     cpu_rvalid,
    output logic [2*`MEM_WORD_W-1:0] cpu_rdata,
    mem_port_if.requester            port
);

    // Set while a captured request waits for its grant
    logic pend;

    // Captured request fields
    logic                   buf_we;
    logic                   buf_is48;
    logic                   buf_signed;
    logic [`MEM_ADDR_W-1:0] buf_addr;
    mem_word_u              buf_wdata;

    mem_word_u ld_word;

    assign cpu_ready = !pend;

    always_ff @(posedge iw_clk) begin
        if (rst) begin
            pend <= 1'b0;
        end else if (pend) begin
            // The buffer empties in the cycle after the grant
            if (port.gnt)
                pend <= 1'b0;
        end else if (cpu_req) begin
            pend <= 1'b1;
        end
    end

    // Fields are loaded only while the buffer is empty
    // They stay put through the data return of a load
    always_ff @(posedge iw_clk) begin
        if (!pend && cpu_req) begin
            buf_we         <= cpu_we;
            buf_is48       <= cpu_is48;
            buf_signed     <= cpu_signed;
            buf_addr       <= cpu_addr;
            buf_wdata.flat <= cpu_wdata;
        end
    end

    assign port.req   = pend;
    assign port.we    = buf_we;
    assign port.is48  = buf_is48;
    assign port.addr  = buf_addr;
    assign port.wdata = buf_wdata;

    // A 24-bit load comes back with a zero upper half
    // A signed one copies bit 23 of the low word through the upper half
    always_comb begin
        ld_word = port.rdata;
        if (!buf_is48 && buf_signed)
            ld_word.half.hi = {`MEM_WORD_W{ld_word.half.lo[`MEM_WORD_W-1]}};
    end

    // Load data arrives one cycle after the grant
    assign cpu_rvalid = port.rvalid;
    assign cpu_rdata  = ld_word.flat;

endmodule

// File: hw/port_arbiter.sv
`timescale 1ns/10ps

// Round-robin arbiter that shares RAM port 0 between the load/store unit
// and the read side of the block copier
module port_arbiter import mem_pkg::*; (
    input logic iw_clk,
    input logic rst,
    mem_port_if.arbiter   lsu,
    mem_port_if.arbiter   cpy,
    mem_port_if.requester ram
);

    // Set when the copier has the next turn in a tie
    logic cpy_turn;

    logic lsu_win;
    logic cpy_win;

    // Owner of the read issued last cycle
    logic lsu_rd_q;
    logic cpy_rd_q;

    mem_word_u wdata_mux;

    // A lone requester always wins, a tie goes to the peer that lost last time
    assign lsu_win = lsu.req && (!cpy.req || !cpy_turn);
    assign cpy_win = cpy.req && (!lsu.req || cpy_turn);

    assign lsu.gnt = lsu_win;
    assign cpy.gnt = cpy_win;

    // The winner's fields go onto the RAM port
    always_comb begin
        wdata_mux = cpy_win ? cpy.wdata : lsu.wdata;
        ram.req   = lsu_win || cpy_win;
        ram.we    = cpy_win ? cpy.we : lsu.we;
        ram.addr  = cpy_win ? cpy.addr : lsu.addr;
        ram.is48  = cpy_win ? cpy.is48 : lsu.is48;
        ram.wdata = wdata_mux;
    end

    // Any grant hands the next tie to the other peer
    // After reset the load/store unit wins the first tie
    always_ff @(posedge iw_clk) begin
        if (rst) begin
            cpy_turn <= 1'b0;
        end else if (lsu_win) begin
            cpy_turn <= 1'b1;
        end else if (cpy_win) begin
            cpy_turn <= 1'b0;
        end
    end

    // The RAM returns read data one cycle after the access, writes return nothing
    always_ff @(posedge iw_clk) begin
        if (rst) begin
            lsu_rd_q <= 1'b0;
            cpy_rd_q <= 1'b0;
        end else begin
            lsu_rd_q <= lsu_win && !lsu.we;
            cpy_rd_q <= cpy_win && !cpy.we;
        end
    end

    // Returned data is steered only to the peer that owns the read
    assign lsu.rvalid = lsu_rd_q;
    assign cpy.rvalid = cpy_rd_q;
    assign lsu.rdata  = lsu_rd_q ? ram.rdata : '0;
    assign cpy.rdata  = cpy_rd_q ? ram.rdata : '0;

endmodule

// File: hw/dual_port_ram.sv
`timescale 1ns/10ps
`include "mem_params.svh"

// Dual-port data RAM of 24-bit words with 24-bit and 48-bit accesses
// A 48-bit access covers {addr+1, addr}, the low half stored at addr
// Reads are registered and see a write made on the other port in the same cycle
module dual_port_ram import mem_pkg::*; (
    input logic iw_clk,
    mem_port_if.memory p0,
    mem_port_if.memory p1
);

    logic [`MEM_WORD_W-1:0] mem [`MEM_DEPTH];

    // Array contents of both ports before forwarding
    mem_word_u base0;
    mem_word_u base1;

    // Read words after forwarding and width selection
    mem_word_u fwd0;
    mem_word_u fwd1;

    // Write strobes of each port, req acts as the write qualifier
    logic wr0;
    logic wr1;

    // Replaces the words of a read with the data written on the other port
    // Addresses wrap at the RAM depth, so addr+1 of the top word is word zero
    function automatic mem_word_u read_fwd(
        input mem_word_u              base,
        input logic [`MEM_ADDR_W-1:0] ra,
        input logic                   r48,
        input logic                   ow,
        input logic [`MEM_ADDR_W-1:0] wa,
        input logic                   w48,
        input mem_word_u              wd
    );
        logic [`MEM_ADDR_W-1:0] ra1;
        logic [`MEM_ADDR_W-1:0] wa1;
        mem_word_u              res;
        ra1 = ra + 1'b1;
        wa1 = wa + 1'b1;
        res = base;
        if (ow) begin
            // The low written word lands at wa
            if (ra == wa)
                res.half.lo = wd.half.lo;
            if (ra1 == wa)
                res.half.hi = wd.half.lo;
            // The high written word lands at wa+1 on a 48-bit write only
            if (w48 && ra == wa1)
                res.half.lo = wd.half.hi;
            if (w48 && ra1 == wa1)
                res.half.hi = wd.half.hi;
        end
        // A 24-bit read returns a zero upper half
        if (!r48)
            res.half.hi = '0;
        return res;
    endfunction

    // Every location starts cleared
    initial begin
        for (int i = 0; i < `MEM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    assign wr0 = p0.req && p0.we;
    assign wr1 = p1.req && p1.we;

    always_comb begin
        base0.half.lo = mem[p0.addr];
        base0.half.hi = mem[p0.addr + 1'b1];
        base1.half.lo = mem[p1.addr];
        base1.half.hi = mem[p1.addr + 1'b1];
    end

    // Port 0 sees writes of port 1 and the other way round
    always_comb begin
        fwd0 = read_fwd(base0, p0.addr, p0.is48, wr1, p1.addr, p1.is48, p1.wdata);
        fwd1 = read_fwd(base1, p1.addr, p1.is48, wr0, p0.addr, p0.is48, p0.wdata);
    end

    // Read data is registered every cycle for the address presented
    always_ff @(posedge iw_clk) begin
        p0.rdata <= fwd0;
        p1.rdata <= fwd1;
    end

    // Writes land at the clock edge
    // Two writes to one word in the same cycle leave the port 1 data
    always_ff @(posedge iw_clk) begin
        if (wr0) begin
            mem[p0.addr] <= p0.wdata.half.lo;
            if (p0.is48)
                mem[p0.addr + 1'b1] <= p0.wdata.half.hi;
        end
        if (wr1) begin
            mem[p1.addr] <= p1.wdata.half.lo;
            if (p1.is48)
                mem[p1.addr + 1'b1] <= p1.wdata.half.hi;
        end
    end

endmodule

// File: hw/mem_port_if.sv
`timescale 1ns/10ps
`include "mem_params.svh"

// One access port of the data RAM
// An access takes place in a cycle where req and gnt are both high
// The requester holds we, addr, wdata and is48 while it waits for gnt
interface mem_port_if import mem_pkg::*; ();

    logic                   req;
    logic                   gnt;
    logic                   we;
    logic [`MEM_ADDR_W-1:0] addr;
    mem_word_u              wdata;
    logic                   is48;
    mem_word_u              rdata;
    // Read data is valid for one cycle, the cycle after the granted read
    logic                   rvalid;

    // Peer side that asks for accesses
    modport requester (
        output req, we, addr, wdata, is48,
        input  gnt, rdata, rvalid
    );

    // Arbiter side that grants accesses and returns read data
    modport arbiter (
        input  req, we, addr, wdata, is48,
        output gnt, rdata, rvalid
    );

    // RAM side; gnt and rvalid belong to the arbiter and are not seen here
    modport memory (
        input  req, we, addr, wdata, is48,
        output rdata
    );

endinterface

// File: hw/mem_pkg.sv
`include "mem_params.svh"

package mem_pkg;

    // One 48-bit memory access, seen either as a flat value or as two words
    // Little-endian layout: lo sits at addr and hi at addr+1
    // A 24-bit access only uses lo and returns hi as zero
    typedef union packed {
        logic [2*`MEM_WORD_W-1:0] flat;
        struct packed {
            logic [`MEM_WORD_W-1:0] hi;
            logic [`MEM_WORD_W-1:0] lo;
        } half;
    } mem_word_u;

endpackage

// File: hw/mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// Geometry of the data memory shared by the core and the block copier

// Word address width; every address wraps modulo the RAM depth
`define MEM_ADDR_W 12

// Width of one storage word, a 48-bit access covers two of them
`define MEM_WORD_W 24

// Number of storage words
`define MEM_DEPTH 4096

`endif
